//--- hdl/core_pkg.sv
package core_pkg;

	// ------------------------------------------------------------------------
	// widths and defaults
	// ------------------------------------------------------------------------

	// register file, alu and data memory word
	localparam int DATA_W_DEF = 16;
	// instruction word from the instruction ram
	localparam int INS_W = 16;
	// instruction ram address
	localparam int IMEM_ADDR_W = 10;
	// full data memory address before the bank split
	localparam int DMEM_ADDR_W_DEF = 10;
	// data memory banks, one chip select each
	localparam int DMEM_BANKS_DEF = 4;
	// general purpose registers r0..r7
	localparam int NUM_REGS = 8;
	localparam int REG_IDX_W = 3;

	// ------------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------------

	// operation class from the decoder
	typedef enum logic [1:0] {
		OPR_NOP = 2'd0,
		OPR_MOV = 2'd1,
		OPR_ALU = 2'd2
	} opr_e;

	// operation code handed to the external alu
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_MUL = 3'd2,
		ALU_DIV = 3'd3,
		ALU_CMP = 3'd4
	} alu_typ_e;

	// alu sequencer states
	typedef enum logic [1:0] {
		ALU_IDLE  = 2'd0,
		ALU_ISSUE = 2'd1,
		ALU_WAIT  = 2'd2
	} alu_state_e;

endpackage

//--- hdl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
	input  logic                            clk,
	input  logic                            arst_n,
	// program counter side
	input  logic                            pc_en,
	input  logic [core_pkg::IMEM_ADDR_W-1:0] pc_addr,
	input  logic [core_pkg::INS_W-1:0]       iram_dat,
	// alu sequencer side
	input  logic                            busy,
	input  logic                            cmp_taken,
	// jump request from the decoder, already qualified by issue
	input  logic                            jmp_req,
	input  logic [core_pkg::IMEM_ADDR_W-1:0] jmp_req_addr,
	// instruction ram and pc_if
	output logic                            iram_en,
	output logic [core_pkg::IMEM_ADDR_W-1:0] iram_addr,
	output logic [core_pkg::INS_W-1:0]       pcif_dat,
	output logic                            lock_req,
	output logic                            jmp_sel,
	output logic [core_pkg::IMEM_ADDR_W-1:0] jmp_addr
);

	// target of a pending compare
	logic [core_pkg::IMEM_ADDR_W-1:0] cmp_addr_q;

	// ------------------------------------------------------------------------
	// fetch gating
	// ------------------------------------------------------------------------

	// pc_if stalls for as long as a multi-cycle alu op is in flight
	assign lock_req  = busy;
	assign iram_en   = pc_en & ~lock_req;
	assign iram_addr = pc_addr;
	assign pcif_dat  = iram_dat;

	// ------------------------------------------------------------------------
	// jumps
	// ------------------------------------------------------------------------

	// one cycle select for either an issued jump or a taken compare
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			jmp_sel <= 1'b0;
		else
			jmp_sel <= jmp_req | cmp_taken;
	end

	// issue only happens with busy low, so the last sample before busy rises
	// is the compare target, and it is frozen until the compare resolves
	always_ff @(posedge clk)
	begin
		if (!busy)
			cmp_addr_q <= jmp_req_addr;
		if (jmp_req)
			jmp_addr <= jmp_req_addr;
		else if (cmp_taken)
			jmp_addr <= cmp_addr_q;
	end

	// pc_if reloads after a jump, so a second select right behind is a fault
	a_jmp_single: assert property (@(posedge clk) disable iff (!arst_n)
		jmp_sel |=> !jmp_sel);

endmodule

//--- hdl/dmem_port.sv
`timescale 1ns/1ps

module dmem_port #(
	parameter int DATA_W      = core_pkg::DATA_W_DEF,
	parameter int DMEM_ADDR_W = core_pkg::DMEM_ADDR_W_DEF,
	parameter int DMEM_BANKS  = core_pkg::DMEM_BANKS_DEF
) (
	// source read, qualified by issue
	input  logic                   src_mem_en,
	input  logic [DMEM_ADDR_W-1:0] src_addr,
	// destination access, qualified by issue
	input  logic                   dst_mem_en,
	input  logic                   dst_mem_rw,
	input  logic [DMEM_ADDR_W-1:0] dst_mem_addr,
	input  logic                   dst_indir,
	// indirect address taken from register bus 2
	input  logic [DMEM_ADDR_W-1:0] indir_addr,
	input  logic [DATA_W-1:0]      gprf_dat1,
	// data ram, rw high means read
	output logic                   dram_en,
	output logic                   dram_rw,
	output logic [DMEM_BANKS-1:0]  dram_cs,
	output logic [DMEM_ADDR_W-$clog2(DMEM_BANKS)-1:0] dram_addr,
	output logic [DATA_W-1:0]      dram_wdat
);

	localparam int BANK_W = $clog2(DMEM_BANKS);
	localparam int SUB_W  = DMEM_ADDR_W - BANK_W;

	logic [DMEM_ADDR_W-1:0] dst_addr;
	logic [DMEM_ADDR_W-1:0] sel_addr;

	// destination access wins over a source read
	assign dst_addr = dst_indir ? indir_addr : dst_mem_addr;
	assign sel_addr = dst_mem_en ? dst_addr : src_addr;

	assign dram_en   = src_mem_en | dst_mem_en;
	assign dram_rw   = dst_mem_en ? dst_mem_rw : 1'b1;
	// low bits address a word inside the bank
	assign dram_addr = sel_addr[SUB_W-1:0];
	// stores always take register bus 1
	assign dram_wdat = gprf_dat1;

	// top bits pick the bank
	always_comb
	begin
		dram_cs = '0;
		if (dram_en)
			dram_cs[sel_addr[DMEM_ADDR_W-1 -: BANK_W]] = 1'b1;
	end

	always_comb
	begin
		if (dram_en)
		begin
			a_cs_onehot: assert final ($onehot(dram_cs))
				else $error("dram_cs not one-hot during a data ram access");
		end
	end

endmodule

//--- hdl/alu_seq.sv
`timescale 1ns/1ps

module alu_seq #(
	parameter int DATA_W = core_pkg::DATA_W_DEF
) (
	input  logic                clk,
	input  logic                arst_n,
	// decoder side
	input  logic                issue,
	input  core_pkg::opr_e      opr,
	input  core_pkg::alu_typ_e  alu_typ,
	input  logic                div_mod,
	// register buses 1 and 2
	input  logic [DATA_W-1:0]   gprf_dat1,
	input  logic [DATA_W-1:0]   gprf_dat2,
	// external alu, res is the quotient and res2 the remainder on a div
	input  logic [DATA_W-1:0]   alu_res,
	input  logic [DATA_W-1:0]   alu_res2,
	input  logic                alu_done,
	output logic                alu_start,
	output core_pkg::alu_typ_e  alu_typ_out,
	output logic [DATA_W-1:0]   alu_o_dat,
	output logic [DATA_W-1:0]   alu_t_dat,
	// to fetch_ctrl and reg_writeback
	output logic                busy,
	output logic                alu_wb,
	output logic [DATA_W-1:0]   alu_wb_dat,
	output logic                cmp_taken
);

	core_pkg::alu_state_e state_q;
	core_pkg::alu_state_e state_d;
	core_pkg::alu_typ_e   typ_q;
	logic                 div_mod_q;
	logic [DATA_W-1:0]    o_dat_q;
	logic [DATA_W-1:0]    t_dat_q;
	logic                 accept;
	logic                 done_seen;

	assign accept = issue && (opr == core_pkg::OPR_ALU) && (state_q == core_pkg::ALU_IDLE);

	// ------------------------------------------------------------------------
	// sequencer fsm
	// ------------------------------------------------------------------------

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			core_pkg::ALU_IDLE:
				if (accept)
					state_d = core_pkg::ALU_ISSUE;
			// start lasts exactly one cycle
			core_pkg::ALU_ISSUE:
				state_d = core_pkg::ALU_WAIT;
			// no bound on the alu latency
			core_pkg::ALU_WAIT:
				if (alu_done)
					state_d = core_pkg::ALU_IDLE;
			default:
				state_d = core_pkg::ALU_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state_q <= core_pkg::ALU_IDLE;
		else
			state_q <= state_d;
	end

	// operands sit on the buses only in the issue cycle
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			typ_q     <= alu_typ;
			div_mod_q <= div_mod;
			o_dat_q   <= gprf_dat1;
			t_dat_q   <= gprf_dat2;
		end
	end

	// ------------------------------------------------------------------------
	// alu handshake and results
	// ------------------------------------------------------------------------

	assign alu_start   = (state_q == core_pkg::ALU_ISSUE);
	assign busy        = (state_q != core_pkg::ALU_IDLE);
	assign alu_typ_out = typ_q;
	assign alu_o_dat   = o_dat_q;
	assign alu_t_dat   = t_dat_q;

	assign done_seen = (state_q == core_pkg::ALU_WAIT) && alu_done;

	// both pulses are registered downstream, landing one cycle after done
	assign alu_wb    = done_seen && (typ_q != core_pkg::ALU_CMP);
	assign cmp_taken = done_seen && (typ_q == core_pkg::ALU_CMP) && alu_res[0];

	// remainder only for a div with div_mod set
	assign alu_wb_dat = (div_mod_q && (typ_q == core_pkg::ALU_DIV)) ? alu_res2 : alu_res;

	// decoder must hold off while lock_req is up
	a_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n)
		busy |-> !issue);

endmodule

//--- hdl/reg_writeback.sv
`timescale 1ns/1ps

module reg_writeback #(
	parameter int DATA_W = core_pkg::DATA_W_DEF
) (
	input  logic                                clk,
	input  logic                                arst_n,
	// decoder side
	input  logic                                issue,
	input  core_pkg::opr_e                      opr,
	input  logic                                imm_en,
	input  logic [DATA_W-1:0]                   imm,
	input  logic                                src_mem_en,
	input  logic [DATA_W-1:0]                   dram_rdat,
	input  logic [core_pkg::REG_IDX_W-1:0]      src_reg,
	input  logic [core_pkg::REG_IDX_W-1:0]      dst_reg,
	input  logic                                dst_wr_en,
	input  logic                                halt,
	// register file read buses
	input  logic [DATA_W-1:0]                   gprf_dat1,
	input  logic [DATA_W-1:0]                   gprf_dat2,
	// alu result from alu_seq
	input  logic                                alu_wb,
	input  logic [DATA_W-1:0]                   alu_wb_dat,
	// register file control
	output logic [core_pkg::NUM_REGS-1:0]       bus1_rsel,
	output logic [core_pkg::NUM_REGS-1:0]       bus2_rsel,
	output logic [core_pkg::NUM_REGS-1:0]       gprf_wsel,
	output logic [DATA_W-1:0]                   gprf_dat,
	output logic [core_pkg::DMEM_ADDR_W_DEF-1:0] indir_addr
);

	logic [DATA_W-1:0]               mov_dat;
	logic                            mov_wr;
	logic [core_pkg::REG_IDX_W-1:0]  alu_dst_q;
	logic [core_pkg::NUM_REGS-1:0]   wsel_d;
	logic [DATA_W-1:0]               dat_d;

	// register index to one-hot select
	function automatic logic [core_pkg::NUM_REGS-1:0] idx_to_sel(
		input logic [core_pkg::REG_IDX_W-1:0] idx
	);
		logic [core_pkg::NUM_REGS-1:0] sel;
		sel = '0;
		sel[idx] = 1'b1;
		return sel;
	endfunction

	// ------------------------------------------------------------------------
	// read selects
	// ------------------------------------------------------------------------

	// bus 1 carries the source, bus 2 the destination
	assign bus1_rsel = idx_to_sel(src_reg);
	assign bus2_rsel = idx_to_sel(dst_reg);

	// indirect data ram address from the low bits of bus 2
	assign indir_addr = gprf_dat2[core_pkg::DMEM_ADDR_W_DEF-1:0];

	// ------------------------------------------------------------------------
	// writeback
	// ------------------------------------------------------------------------

	// immediate first, then data ram, then bus 1
	assign mov_dat = imm_en ? imm : (src_mem_en ? dram_rdat : gprf_dat1);
	// halt from pc_if kills the move strobe
	assign mov_wr  = issue && (opr == core_pkg::OPR_MOV) && dst_wr_en && !halt;

	// destination of the alu op in flight
	always_ff @(posedge clk)
	begin
		if (issue && (opr == core_pkg::OPR_ALU))
			alu_dst_q <= dst_reg;
	end

	// lock_req keeps a move from ever meeting an alu writeback
	always_comb
	begin
		wsel_d = '0;
		dat_d  = mov_dat;
		if (alu_wb)
		begin
			wsel_d = idx_to_sel(alu_dst_q);
			dat_d  = alu_wb_dat;
		end
		else if (mov_wr)
			wsel_d = idx_to_sel(dst_reg);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			gprf_wsel <= '0;
		else
			gprf_wsel <= wsel_d;
	end

	always_ff @(posedge clk)
	begin
		if (alu_wb || mov_wr)
			gprf_dat <= dat_d;
	end

	// alu writeback and a move never share a cycle
	a_wsel_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
		!(alu_wb && mov_wr));

endmodule

//--- hdl/core_mem_wrapper.sv
`timescale 1ns/1ps

module core_mem_wrapper #(
	parameter int DATA_W     = core_pkg::DATA_W_DEF,
	parameter int DMEM_BANKS = core_pkg::DMEM_BANKS_DEF
) (
	input  logic                                clk,
	input  logic                                arst_n,
	// pc_if and instruction ram
	input  logic                                pc_en,
	input  logic [core_pkg::IMEM_ADDR_W-1:0]     pc_addr,
	input  logic                                halt,
	input  logic [core_pkg::INS_W-1:0]           iram_dat,
	output logic                                iram_en,
	output logic [core_pkg::IMEM_ADDR_W-1:0]     iram_addr,
	output logic [core_pkg::INS_W-1:0]           pcif_dat,
	output logic                                lock_req,
	output logic                                jmp_sel,
	output logic [core_pkg::IMEM_ADDR_W-1:0]     jmp_addr,
	// decoder
	input  logic                                issue,
	input  core_pkg::opr_e                      opr,
	input  core_pkg::alu_typ_e                  alu_typ,
	input  logic                                div_mod,
	input  logic                                imm_en,
	input  logic [DATA_W-1:0]                   imm,
	input  logic                                src_mem_en,
	input  logic [core_pkg::DMEM_ADDR_W_DEF-1:0] src_addr,
	input  logic [core_pkg::REG_IDX_W-1:0]      src_reg,
	input  logic [core_pkg::REG_IDX_W-1:0]      dst_reg,
	input  logic                                dst_wr_en,
	input  logic                                dst_mem_en,
	input  logic                                dst_mem_rw,
	input  logic [core_pkg::DMEM_ADDR_W_DEF-1:0] dst_mem_addr,
	input  logic                                dst_indir,
	input  logic                                jmp_en,
	// jump target that travels with the instruction
	input  logic [core_pkg::IMEM_ADDR_W-1:0]     jmp_req_addr,
	// data ram
	input  logic [DATA_W-1:0]                   dram_rdat,
	output logic                                dram_en,
	output logic                                dram_rw,
	output logic [DMEM_BANKS-1:0]               dram_cs,
	output logic [core_pkg::DMEM_ADDR_W_DEF-$clog2(DMEM_BANKS)-1:0] dram_addr,
	output logic [DATA_W-1:0]                   dram_wdat,
	// register file
	input  logic [DATA_W-1:0]                   gprf_dat1,
	input  logic [DATA_W-1:0]                   gprf_dat2,
	output logic [core_pkg::NUM_REGS-1:0]       bus1_rsel,
	output logic [core_pkg::NUM_REGS-1:0]       bus2_rsel,
	output logic [core_pkg::NUM_REGS-1:0]       gprf_wsel,
	output logic [DATA_W-1:0]                   gprf_dat,
	// alu
	input  logic [DATA_W-1:0]                   alu_res,
	input  logic [DATA_W-1:0]                   alu_res2,
	input  logic                                alu_done,
	output logic                                alu_start,
	output core_pkg::alu_typ_e                  alu_typ_out,
	output logic [DATA_W-1:0]                   alu_o_dat,
	output logic [DATA_W-1:0]                   alu_t_dat
);

	logic                                 busy;
	logic                                 cmp_taken;
	logic                                 alu_wb;
	logic [DATA_W-1:0]                    alu_wb_dat;
	logic [core_pkg::DMEM_ADDR_W_DEF-1:0] indir_addr;

	// ------------------------------------------------------------------------
	// fetch gating and jumps
	// ------------------------------------------------------------------------

	fetch_ctrl i_fetch_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.pc_en        (pc_en),
		.pc_addr      (pc_addr),
		.iram_dat     (iram_dat),
		.busy         (busy),
		.cmp_taken    (cmp_taken),
		.jmp_req      (issue & jmp_en),
		.jmp_req_addr (jmp_req_addr),
		.iram_en      (iram_en),
		.iram_addr    (iram_addr),
		.pcif_dat     (pcif_dat),
		.lock_req     (lock_req),
		.jmp_sel      (jmp_sel),
		.jmp_addr     (jmp_addr)
	);

	// ------------------------------------------------------------------------
	// data ram port
	// ------------------------------------------------------------------------

	dmem_port #(
		.DATA_W      (DATA_W),
		.DMEM_ADDR_W (core_pkg::DMEM_ADDR_W_DEF),
		.DMEM_BANKS  (DMEM_BANKS)
	) i_dmem_port (
		.src_mem_en   (issue & src_mem_en),
		.src_addr     (src_addr),
		.dst_mem_en   (issue & dst_mem_en),
		.dst_mem_rw   (dst_mem_rw),
		.dst_mem_addr (dst_mem_addr),
		.dst_indir    (dst_indir),
		.indir_addr   (indir_addr),
		.gprf_dat1    (gprf_dat1),
		.dram_en      (dram_en),
		.dram_rw      (dram_rw),
		.dram_cs      (dram_cs),
		.dram_addr    (dram_addr),
		.dram_wdat    (dram_wdat)
	);

	// ------------------------------------------------------------------------
	// alu sequencing and register writeback
	// ------------------------------------------------------------------------

	alu_seq #(
		.DATA_W (DATA_W)
	) i_alu_seq (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue       (issue),
		.opr         (opr),
		.alu_typ     (alu_typ),
		.div_mod     (div_mod),
		.gprf_dat1   (gprf_dat1),
		.gprf_dat2   (gprf_dat2),
		.alu_res     (alu_res),
		.alu_res2    (alu_res2),
		.alu_done    (alu_done),
		.alu_start   (alu_start),
		.alu_typ_out (alu_typ_out),
		.alu_o_dat   (alu_o_dat),
		.alu_t_dat   (alu_t_dat),
		.busy        (busy),
		.alu_wb      (alu_wb),
		.alu_wb_dat  (alu_wb_dat),
		.cmp_taken   (cmp_taken)
	);

	reg_writeback #(
		.DATA_W (DATA_W)
	) i_reg_writeback (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue      (issue),
		.opr        (opr),
		.imm_en     (imm_en),
		.imm        (imm),
		.src_mem_en (src_mem_en),
		.dram_rdat  (dram_rdat),
		.src_reg    (src_reg),
		.dst_reg    (dst_reg),
		.dst_wr_en  (dst_wr_en),
		.halt       (halt),
		.gprf_dat1  (gprf_dat1),
		.gprf_dat2  (gprf_dat2),
		.alu_wb     (alu_wb),
		.alu_wb_dat (alu_wb_dat),
		.bus1_rsel  (bus1_rsel),
		.bus2_rsel  (bus2_rsel),
		.gprf_wsel  (gprf_wsel),
		.gprf_dat   (gprf_dat),
		.indir_addr (indir_addr)
	);

endmodule

//--- tb/tb_core_vectors.svh
// one row per instruction, applied in order by the testbench
// columns: opr typ div_mod imm_en imm / src_mem_en src_addr src_reg dst_reg dst_wr_en
//          dst_mem_en dst_mem_rw dst_mem_addr dst_indir / jmp_en jmp_addr halt
//          gprf_dat1 gprf_dat2 dram_rdat / exp_wr exp_dat (exp_dat unused for alu rows)

localparam int NUM_VECS = 15;

typedef struct {
	core_pkg::opr_e                          opr;
	core_pkg::alu_typ_e                      typ;
	logic                                    div_mod;
	logic                                    imm_en;
	logic [core_pkg::DATA_W_DEF-1:0]         imm;
	logic                                    src_mem_en;
	logic [core_pkg::DMEM_ADDR_W_DEF-1:0]    src_addr;
	logic [core_pkg::REG_IDX_W-1:0]          src_reg;
	logic [core_pkg::REG_IDX_W-1:0]          dst_reg;
	logic                                    dst_wr_en;
	logic                                    dst_mem_en;
	logic                                    dst_mem_rw;
	logic [core_pkg::DMEM_ADDR_W_DEF-1:0]    dst_mem_addr;
	logic                                    dst_indir;
	logic                                    jmp_en;
	logic [core_pkg::IMEM_ADDR_W-1:0]        jmp_addr;
	logic                                    halt;
	logic [core_pkg::DATA_W_DEF-1:0]         dat1;
	logic [core_pkg::DATA_W_DEF-1:0]         dat2;
	logic [core_pkg::DATA_W_DEF-1:0]         rdat;
	logic                                    exp_wr;
	logic [core_pkg::DATA_W_DEF-1:0]         exp_dat;
} vec_t;

vec_t vecs [NUM_VECS];

task automatic load_vectors();
	// immediate into r5
	vecs[0]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b1, 16'h1234,
		1'b0, 10'h000, 3'd1, 3'd5, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h0000, 16'h0000, 16'h0000, 1'b1, 16'h1234};
	// load from bank 2, word a5
	vecs[1]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b1, 10'h2a5, 3'd2, 3'd3, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h1111, 16'h2222, 16'hbeef, 1'b1, 16'hbeef};
	// register to register through bus 1
	vecs[2]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd4, 3'd6, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h5a5a, 16'h0000, 16'h0000, 1'b1, 16'h5a5a};
	// direct store to bank 1
	vecs[3]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd7, 3'd0, 1'b0, 1'b1, 1'b0, 10'h1c3, 1'b0,
		1'b0, 10'h000, 1'b0, 16'hcafe, 16'h0000, 16'h0000, 1'b0, 16'h0000};
	// indirect store, address from bus 2 low bits
	vecs[4]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd1, 3'd2, 1'b0, 1'b1, 1'b0, 10'h000, 1'b1,
		1'b0, 10'h000, 1'b0, 16'h0bad, 16'hf37e, 16'h0000, 1'b0, 16'h0000};
	// source and destination together, destination owns the port
	vecs[5]  = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b1, 10'h011, 3'd3, 3'd4, 1'b1, 1'b1, 1'b0, 10'h322, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h4321, 16'h0000, 16'h7777, 1'b1, 16'h7777};
	// alu ops
	vecs[6]  = '{core_pkg::OPR_ALU, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd1, 3'd2, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h1234, 16'h0ff0, 16'h0000, 1'b1, 16'h0000};
	vecs[7]  = '{core_pkg::OPR_ALU, core_pkg::ALU_SUB, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd3, 3'd4, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h0100, 16'h0003, 16'h0000, 1'b1, 16'h0000};
	// mul with div_mod set still writes the product
	vecs[8]  = '{core_pkg::OPR_ALU, core_pkg::ALU_MUL, 1'b1, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd5, 3'd6, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h0012, 16'h0034, 16'h0000, 1'b1, 16'h0000};
	// div, quotient then remainder
	vecs[9]  = '{core_pkg::OPR_ALU, core_pkg::ALU_DIV, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd7, 3'd1, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h0064, 16'h0007, 16'h0000, 1'b1, 16'h0000};
	vecs[10] = '{core_pkg::OPR_ALU, core_pkg::ALU_DIV, 1'b1, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd2, 3'd0, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b0, 16'h0064, 16'h0007, 16'h0000, 1'b1, 16'h0000};
	// compare, equal operands take the jump
	vecs[11] = '{core_pkg::OPR_ALU, core_pkg::ALU_CMP, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd1, 3'd3, 1'b0, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h155, 1'b0, 16'h0042, 16'h0042, 16'h0000, 1'b0, 16'h0000};
	vecs[12] = '{core_pkg::OPR_ALU, core_pkg::ALU_CMP, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd4, 3'd5, 1'b0, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h0aa, 1'b0, 16'h0001, 16'h0002, 16'h0000, 1'b0, 16'h0000};
	// unconditional jump
	vecs[13] = '{core_pkg::OPR_NOP, core_pkg::ALU_ADD, 1'b0, 1'b0, 16'h0000,
		1'b0, 10'h000, 3'd0, 3'd0, 1'b0, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b1, 10'h2c8, 1'b0, 16'h0000, 16'h0000, 16'h0000, 1'b0, 16'h0000};
	// halted move leaves r7 alone
	vecs[14] = '{core_pkg::OPR_MOV, core_pkg::ALU_ADD, 1'b0, 1'b1, 16'h0f0f,
		1'b0, 10'h000, 3'd6, 3'd7, 1'b1, 1'b0, 1'b0, 10'h000, 1'b0,
		1'b0, 10'h000, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1'b0, 16'h0000};
endtask

//--- tb/tb_core_mem_wrapper.sv
`timescale 1ns/1ps

module tb_core_mem_wrapper;

	localparam int DATA_W     = core_pkg::DATA_W_DEF;
	localparam int DMEM_BANKS = core_pkg::DMEM_BANKS_DEF;
	localparam int SUB_W      = core_pkg::DMEM_ADDR_W_DEF - $clog2(DMEM_BANKS);

	logic                                 clk;
	logic                                 arst_n;
	logic                                 pc_en;
	logic [core_pkg::IMEM_ADDR_W-1:0]     pc_addr;
	logic                                 halt;
	logic [core_pkg::INS_W-1:0]           iram_dat;
	logic                                 iram_en;
	logic [core_pkg::IMEM_ADDR_W-1:0]     iram_addr;
	logic [core_pkg::INS_W-1:0]           pcif_dat;
	logic                                 lock_req;
	logic                                 jmp_sel;
	logic [core_pkg::IMEM_ADDR_W-1:0]     jmp_addr;
	logic                                 issue;
	core_pkg::opr_e                       opr;
	core_pkg::alu_typ_e                   alu_typ;
	logic                                 div_mod;
	logic                                 imm_en;
	logic [DATA_W-1:0]                    imm;
	logic                                 src_mem_en;
	logic [core_pkg::DMEM_ADDR_W_DEF-1:0] src_addr;
	logic [core_pkg::REG_IDX_W-1:0]       src_reg;
	logic [core_pkg::REG_IDX_W-1:0]       dst_reg;
	logic                                 dst_wr_en;
	logic                                 dst_mem_en;
	logic                                 dst_mem_rw;
	logic [core_pkg::DMEM_ADDR_W_DEF-1:0] dst_mem_addr;
	logic                                 dst_indir;
	logic                                 jmp_en;
	logic [core_pkg::IMEM_ADDR_W-1:0]     jmp_req_addr;
	logic [DATA_W-1:0]                    dram_rdat;
	logic                                 dram_en;
	logic                                 dram_rw;
	logic [DMEM_BANKS-1:0]                dram_cs;
	logic [SUB_W-1:0]                     dram_addr;
	logic [DATA_W-1:0]                    dram_wdat;
	logic [DATA_W-1:0]                    gprf_dat1;
	logic [DATA_W-1:0]                    gprf_dat2;
	logic [core_pkg::NUM_REGS-1:0]        bus1_rsel;
	logic [core_pkg::NUM_REGS-1:0]        bus2_rsel;
	logic [core_pkg::NUM_REGS-1:0]        gprf_wsel;
	logic [DATA_W-1:0]                    gprf_dat;
	logic [DATA_W-1:0]                    alu_res;
	logic [DATA_W-1:0]                    alu_res2;
	logic                                 alu_done;
	logic                                 alu_start;
	core_pkg::alu_typ_e                   alu_typ_out;
	logic [DATA_W-1:0]                    alu_o_dat;
	logic [DATA_W-1:0]                    alu_t_dat;

	int seed;

	`include "tb_core_vectors.svh"

	core_mem_wrapper #(
		.DATA_W     (DATA_W),
		.DMEM_BANKS (DMEM_BANKS)
	) i_dut (.*);

	// 20 ns clock
	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// reference alu, cmp reports equality in bit 0
	function automatic logic [DATA_W-1:0] alu_model(input core_pkg::alu_typ_e typ,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (typ)
			core_pkg::ALU_ADD: return a + b;
			core_pkg::ALU_SUB: return a - b;
			core_pkg::ALU_MUL: return a * b;
			core_pkg::ALU_DIV: return a / b;
			default:           return {{(DATA_W-1){1'b0}}, a == b};
		endcase
	endfunction

	task automatic drive_idle();
		issue        = 1'b0;
		opr          = core_pkg::OPR_NOP;
		alu_typ      = core_pkg::ALU_ADD;
		{div_mod, imm_en, src_mem_en, dst_wr_en, halt} = '0;
		{dst_mem_en, dst_mem_rw, dst_indir, jmp_en, alu_done} = '0;
		{imm, src_addr, src_reg, dst_reg, dst_mem_addr, jmp_req_addr} = '0;
		{gprf_dat1, gprf_dat2, dram_rdat, alu_res, alu_res2} = '0;
	endtask

	task automatic drive_row(input vec_t v);
		issue        = 1'b1;
		opr          = v.opr;
		alu_typ      = v.typ;
		div_mod      = v.div_mod;
		imm_en       = v.imm_en;
		imm          = v.imm;
		src_mem_en   = v.src_mem_en;
		src_addr     = v.src_addr;
		src_reg      = v.src_reg;
		dst_reg      = v.dst_reg;
		dst_wr_en    = v.dst_wr_en;
		dst_mem_en   = v.dst_mem_en;
		dst_mem_rw   = v.dst_mem_rw;
		dst_mem_addr = v.dst_mem_addr;
		dst_indir    = v.dst_indir;
		jmp_en       = v.jmp_en;
		jmp_req_addr = v.jmp_addr;
		halt         = v.halt;
		gprf_dat1    = v.dat1;
		gprf_dat2    = v.dat2;
		dram_rdat    = v.rdat;
	endtask

	// data ram port is combinational in the issue cycle
	task automatic check_dram(input vec_t v);
		logic [core_pkg::DMEM_ADDR_W_DEF-1:0] addr;
		logic                                 en;
		logic                                 rw;
		en = v.src_mem_en | v.dst_mem_en;
		if (v.dst_mem_en)
		begin
			addr = v.dst_indir ? v.dat2[core_pkg::DMEM_ADDR_W_DEF-1:0] : v.dst_mem_addr;
			rw   = v.dst_mem_rw;
		end
		else
		begin
			addr = v.src_addr;
			rw   = 1'b1;
		end
		check_val("dram_en", dram_en, en);
		check_val("dram_cs", dram_cs, en ? (1 << (addr >> SUB_W)) : 0);
		if (en)
		begin
			check_val("dram_rw", dram_rw, rw);
			check_val("dram_addr", dram_addr, addr[SUB_W-1:0]);
			check_val("dram_wdat", dram_wdat, v.dat1);
		end
	endtask

	// start pulse, random done delay, then the write or the jump
	task automatic run_alu(input vec_t v);
		int                delay;
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] exp_dat;
		logic              taken;
		res     = alu_model(v.typ, v.dat1, v.dat2);
		exp_dat = (v.typ == core_pkg::ALU_DIV && v.div_mod) ? v.dat1 % v.dat2 : res;
		taken   = (v.typ == core_pkg::ALU_CMP) && res[0];
		delay   = 1 + ($unsigned($random(seed)) % 6);
		check_val("alu_start", alu_start, 1'b1);
		check_val("lock_req", lock_req, 1'b1);
		check_val("iram_en", iram_en, 1'b0);
		check_val("alu_typ_out", alu_typ_out, v.typ);
		check_val("alu_o_dat", alu_o_dat, v.dat1);
		check_val("alu_t_dat", alu_t_dat, v.dat2);
		drive_idle();
		repeat (delay)
		begin
			@(negedge clk);
			check_val("alu_start", alu_start, 1'b0);
			check_val("lock_req", lock_req, 1'b1);
			check_val("iram_en", iram_en, 1'b0);
			check_val("gprf_wsel", gprf_wsel, 0);
			check_val("jmp_sel", jmp_sel, 1'b0);
		end
		alu_done = 1'b1;
		alu_res  = res;
		alu_res2 = (v.typ == core_pkg::ALU_DIV) ? v.dat1 % v.dat2 : '0;
		@(negedge clk);
		// fetch reopens in the cycle after done
		check_val("lock_req", lock_req, 1'b0);
		check_val("iram_en", iram_en, pc_en);
		check_val("gprf_wsel", gprf_wsel, v.exp_wr ? (1 << v.dst_reg) : 0);
		if (v.exp_wr)
			check_val("gprf_dat", gprf_dat, exp_dat);
		check_val("jmp_sel", jmp_sel, taken);
		if (taken)
			check_val("jmp_addr", jmp_addr, v.jmp_addr);
		drive_idle();
	endtask

	task automatic apply_row(input int i);
		vec_t v;
		v = vecs[i];
		@(negedge clk);
		drive_row(v);
		pc_addr  = 10'h3a0 + i;
		iram_dat = 16'h8000 | i;
		// fetch enable alternates from row to row
		pc_en    = (i % 2 == 0);
		#1;
		check_val("bus1_rsel", bus1_rsel, 1 << v.src_reg);
		check_val("bus2_rsel", bus2_rsel, 1 << v.dst_reg);
		check_val("iram_addr", iram_addr, 10'h3a0 + i);
		check_val("pcif_dat", pcif_dat, 16'h8000 | i);
		check_val("lock_req", lock_req, 1'b0);
		check_val("iram_en", iram_en, pc_en);
		check_dram(v);
		@(negedge clk);
		if (v.opr == core_pkg::OPR_ALU)
			run_alu(v);
		else
		begin
			check_val("lock_req", lock_req, 1'b0);
			check_val("gprf_wsel", gprf_wsel, v.exp_wr ? (1 << v.dst_reg) : 0);
			if (v.exp_wr)
				check_val("gprf_dat", gprf_dat, v.exp_dat);
			check_val("jmp_sel", jmp_sel, v.jmp_en);
			if (v.jmp_en)
				check_val("jmp_addr", jmp_addr, v.jmp_addr);
			drive_idle();
		end
		// strobes last one cycle only
		@(negedge clk);
		check_val("gprf_wsel", gprf_wsel, 0);
		check_val("jmp_sel", jmp_sel, 1'b0);
	endtask

	// ------------------------------------------------------------------------
	// sequence and watchdog
	// ------------------------------------------------------------------------

	initial
	begin
		seed     = 54;
		clk      = 1'b0;
		arst_n   = 1'b0;
		pc_en    = 1'b1;
		pc_addr  = '0;
		iram_dat = '0;
		drive_idle();
		load_vectors();
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_val("lock_req", lock_req, 1'b0);
		check_val("alu_start", alu_start, 1'b0);
		check_val("jmp_sel", jmp_sel, 1'b0);
		check_val("gprf_wsel", gprf_wsel, 0);
		check_val("dram_en", dram_en, 1'b0);
		arst_n = 1'b1;
		for (int i = 0; i < NUM_VECS; i++)
			apply_row(i);
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial
	begin
		#((NUM_VECS * 12 + 20) * 20);
		$display("timeout: the instruction sequence did not complete in time");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- Bender.yml
package:
  name: core_mem_wrapper

sources:
  - hdl/core_pkg.sv
  - hdl/fetch_ctrl.sv
  - hdl/dmem_port.sv
  - hdl/alu_seq.sv
  - hdl/reg_writeback.sv
  - hdl/core_mem_wrapper.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_core_mem_wrapper.sv

//--- project.f
+incdir+tb
hdl/core_pkg.sv
hdl/fetch_ctrl.sv
hdl/dmem_port.sv
hdl/alu_seq.sv
hdl/reg_writeback.sv
hdl/core_mem_wrapper.sv
tb/tb_core_mem_wrapper.sv
